// File: verilog/mips_exec_pkg.sv
package mips_exec_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    localparam reg_idx_t link_reg = 5'd31; // jal writes here

    // Major opcodes kept in this slice
    typedef enum logic [5:0] {
        op_special = 6'b000000,
        op_jal     = 6'b000011,
        op_beq     = 6'b000100,
        op_bne     = 6'b000101,
        op_addi    = 6'b001000,
        op_andi    = 6'b001100,
        op_ori     = 6'b001101,
        op_lui     = 6'b001111
    } opcode_e;

    // Function codes under op_special
    typedef enum logic [5:0] {
        fn_sll  = 6'b000000,
        fn_jr   = 6'b001000,
        fn_add  = 6'b100000,
        fn_sub  = 6'b100010,
        fn_and  = 6'b100100,
        fn_or   = 6'b100101,
        fn_slt  = 6'b101010,
        fn_sltu = 6'b101011
    } funct_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_sll
    } alu_op_e;

    typedef enum logic [1:0] {
        npc_seq,
        npc_branch,
        npc_j26,
        npc_jr
    } npc_op_e;

    typedef enum logic [1:0] {
        dest_rd,
        dest_rt,
        dest_link,
        dest_none
    } dest_sel_e;

    typedef enum logic [1:0] {
        res_alu,
        res_set,
        res_link
    } res_sel_e;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      use_imm;      // Operand B from imm16
        logic      imm_signed;
        logic      lui_shift;    // Shift by 16, not shamt
        logic      set_unsigned;
        npc_op_e   npc_op;
        logic      branch_ne;
        dest_sel_e dest_sel;
        res_sel_e  res_sel;
        logic      illegal;
    } ctrl_t;

    typedef struct packed {
        reg_idx_t    rs;
        reg_idx_t    rt;
        reg_idx_t    rd;
        logic [4:0]  shamt;
        logic [15:0] imm16;
        logic [25:0] imm26;
    } fields_t;

    typedef struct packed {
        logic     we;
        reg_idx_t dest;
        word_t    data;
    } wb_t;

endpackage

// File: verilog/inst_decoder.sv
`timescale 1ns/10ps
module inst_decoder (
    input  mips_exec_pkg::word_t   instr,
    output mips_exec_pkg::ctrl_t   ctrl,
    output mips_exec_pkg::fields_t fields
);
    import mips_exec_pkg::*;

    opcode_e opcode;
    funct_e  funct;

    assign opcode = opcode_e'(instr[31:26]);
    assign funct  = funct_e'(instr[5:0]);

    // Raw fields, meaning depends on format
    assign fields = '{
        rs:    instr[25:21],
        rt:    instr[20:16],
        rd:    instr[15:11],
        shamt: instr[10:6],
        imm16: instr[15:0],
        imm26: instr[25:0]
    };

    always_comb begin
        ctrl.alu_op       = alu_add;
        ctrl.use_imm      = 1'b0;
        ctrl.imm_signed   = 1'b0;
        ctrl.lui_shift    = 1'b0;
        ctrl.set_unsigned = 1'b0;
        ctrl.npc_op       = npc_seq;
        ctrl.branch_ne    = 1'b0;
        ctrl.dest_sel     = dest_none;
        ctrl.res_sel      = res_alu;
        ctrl.illegal      = 1'b0;

        case (opcode)
            op_special: begin
                ctrl.dest_sel = dest_rd;
                case (funct)
                    fn_add:  ctrl.alu_op = alu_add;
                    fn_sub:  ctrl.alu_op = alu_sub;
                    fn_and:  ctrl.alu_op = alu_and;
                    fn_or:   ctrl.alu_op = alu_or;
                    fn_sll:  ctrl.alu_op = alu_sll;
                    fn_slt:  ctrl.res_sel = res_set;
                    fn_sltu: begin
                        ctrl.res_sel      = res_set;
                        ctrl.set_unsigned = 1'b1;
                    end
                    fn_jr: begin
                        ctrl.npc_op   = npc_jr;
                        ctrl.dest_sel = dest_none; // No link
                    end
                    default: begin
                        ctrl.illegal  = 1'b1;
                        ctrl.dest_sel = dest_none;
                    end
                endcase
            end
            op_addi: begin
                ctrl.use_imm    = 1'b1;
                ctrl.imm_signed = 1'b1;
                ctrl.dest_sel   = dest_rt;
            end
            op_andi: begin
                ctrl.alu_op   = alu_and;
                ctrl.use_imm  = 1'b1;
                ctrl.dest_sel = dest_rt;
            end
            op_ori: begin
                ctrl.alu_op   = alu_or;
                ctrl.use_imm  = 1'b1;
                ctrl.dest_sel = dest_rt;
            end
            op_lui: begin
                // Immediate shifted into upper half
                ctrl.alu_op    = alu_sll;
                ctrl.use_imm   = 1'b1;
                ctrl.lui_shift = 1'b1;
                ctrl.dest_sel  = dest_rt;
            end
            op_beq: ctrl.npc_op = npc_branch;
            op_bne: begin
                ctrl.npc_op    = npc_branch;
                ctrl.branch_ne = 1'b1;
            end
            op_jal: begin
                ctrl.npc_op   = npc_j26;
                ctrl.dest_sel = dest_link;
                ctrl.res_sel  = res_link;
            end
            default: ctrl.illegal = 1'b1;
        endcase
    end

endmodule

// File: verilog/alu_unit.sv
`timescale 1ns/10ps
module alu_unit (
    input  mips_exec_pkg::ctrl_t   ctrl,
    input  mips_exec_pkg::fields_t fields,
    input  mips_exec_pkg::word_t   rs_val,
    input  mips_exec_pkg::word_t   rt_val,
    output mips_exec_pkg::word_t   result
);
    import mips_exec_pkg::*;

    word_t      imm_ext;
    word_t      op_b;
    logic [4:0] shift_amt;

    always_comb begin
        if (ctrl.imm_signed) begin
            imm_ext = {{16{fields.imm16[15]}}, fields.imm16};
        end else begin
            imm_ext = {16'b0, fields.imm16};
        end
    end

    assign op_b      = ctrl.use_imm ? imm_ext : rt_val;
    assign shift_amt = ctrl.lui_shift ? 5'd16 : fields.shamt; // lui moves imm up

    // Wraps modulo 2^32, no overflow trap
    always_comb begin
        case (ctrl.alu_op)
            alu_add: result = rs_val + op_b;
            alu_sub: result = rs_val - op_b;
            alu_and: result = rs_val & op_b;
            alu_or:  result = rs_val | op_b;
            alu_sll: result = op_b << shift_amt;
            default: result = rs_val + op_b;
        endcase
    end

endmodule

// File: verilog/compare_unit.sv
`timescale 1ns/10ps
module compare_unit (
    input  mips_exec_pkg::ctrl_t ctrl,
    input  mips_exec_pkg::word_t rs_val,
    input  mips_exec_pkg::word_t rt_val,
    output logic                 equal,
    output mips_exec_pkg::word_t set_result
);

    logic less;

    assign equal = (rs_val == rt_val); // Branch condition source

    always_comb begin
        if (ctrl.set_unsigned) begin
            less = (rs_val < rt_val);
        end else begin
            less = ($signed(rs_val) < $signed(rt_val));
        end
    end

    assign set_result = {31'b0, less};

endmodule

// File: verilog/next_pc_unit.sv
`timescale 1ns/10ps
module next_pc_unit (
    input  mips_exec_pkg::ctrl_t   ctrl,
    input  mips_exec_pkg::fields_t fields,
    input  mips_exec_pkg::word_t   pc,
    input  mips_exec_pkg::word_t   rs_val,
    input  logic                   equal,
    output mips_exec_pkg::word_t   npc,
    output logic                   taken,
    output mips_exec_pkg::word_t   link_addr
);
    import mips_exec_pkg::*;

    word_t pc_plus4;
    word_t branch_target;
    word_t jump_target;
    logic  cond;

    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc_plus4 + {{14{fields.imm16[15]}}, fields.imm16, 2'b00};
    assign jump_target   = {pc_plus4[31:28], fields.imm26, 2'b00};
    assign link_addr     = pc + 32'd8; // Past the delay slot
    assign cond          = equal ^ ctrl.branch_ne; // bne inverts the sense

    always_comb begin
        npc   = pc_plus4;
        taken = 1'b0;
        case (ctrl.npc_op)
            npc_branch: begin
                if (cond) begin
                    npc   = branch_target;
                    taken = 1'b1;
                end
            end
            npc_j26: begin
                npc   = jump_target;
                taken = 1'b1;
            end
            npc_jr: begin
                npc   = rs_val;
                taken = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: verilog/result_select.sv
`timescale 1ns/10ps
module result_select (
    input  mips_exec_pkg::ctrl_t   ctrl,
    input  mips_exec_pkg::fields_t fields,
    input  mips_exec_pkg::word_t   alu_result,
    input  mips_exec_pkg::word_t   set_result,
    input  mips_exec_pkg::word_t   link_addr,
    output mips_exec_pkg::wb_t     wb
);
    import mips_exec_pkg::*;

    word_t    data;
    reg_idx_t dest;
    logic     has_dest;

    always_comb begin
        case (ctrl.res_sel)
            res_set:  data = set_result;
            res_link: data = link_addr;
            default:  data = alu_result;
        endcase
    end

    always_comb begin
        has_dest = 1'b1;
        case (ctrl.dest_sel)
            dest_rd:   dest = fields.rd;
            dest_rt:   dest = fields.rt;
            dest_link: dest = link_reg;
            default: begin
                dest     = '0;
                has_dest = 1'b0;
            end
        endcase
    end

    // $zero is never written
    always_comb begin
        wb.we   = has_dest && (dest != '0);
        wb.dest = dest;
        wb.data = data;
    end

endmodule

// File: verilog/mips_exec_top.sv
`timescale 1ns/10ps
module mips_exec_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    input  mips_exec_pkg::word_t in_instr,
    input  mips_exec_pkg::word_t in_pc,
    input  mips_exec_pkg::word_t in_rs_val,
    input  mips_exec_pkg::word_t in_rt_val,
    output logic                 out_valid,
    output mips_exec_pkg::wb_t   out_wb,
    output mips_exec_pkg::word_t out_npc,
    output logic                 out_taken,
    output logic                 out_illegal
);
    import mips_exec_pkg::*;

    ctrl_t   dec_ctrl;
    fields_t dec_fields;

    // Stage 1
    logic    s1_valid;
    ctrl_t   s1_ctrl;
    fields_t s1_fields;
    word_t   s1_pc;
    word_t   s1_rs_val;
    word_t   s1_rt_val;

    word_t   alu_result;
    word_t   set_result;
    word_t   link_addr;
    word_t   npc;
    logic    equal;
    logic    taken;
    wb_t     wb;

    inst_decoder inst_decoder_i (
        .instr  (in_instr),
        .ctrl   (dec_ctrl),
        .fields (dec_fields)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_ctrl   <= dec_ctrl;
            s1_fields <= dec_fields;
            s1_pc     <= in_pc;
            s1_rs_val <= in_rs_val;
            s1_rt_val <= in_rt_val;
        end
    end

    alu_unit alu_unit_i (
        .ctrl   (s1_ctrl),
        .fields (s1_fields),
        .rs_val (s1_rs_val),
        .rt_val (s1_rt_val),
        .result (alu_result)
    );

    compare_unit compare_unit_i (
        .ctrl       (s1_ctrl),
        .rs_val     (s1_rs_val),
        .rt_val     (s1_rt_val),
        .equal      (equal),
        .set_result (set_result)
    );

    next_pc_unit next_pc_unit_i (
        .ctrl      (s1_ctrl),
        .fields    (s1_fields),
        .pc        (s1_pc),
        .rs_val    (s1_rs_val),
        .equal     (equal),
        .npc       (npc),
        .taken     (taken),
        .link_addr (link_addr)
    );

    result_select result_select_i (
        .ctrl       (s1_ctrl),
        .fields     (s1_fields),
        .alu_result (alu_result),
        .set_result (set_result),
        .link_addr  (link_addr),
        .wb         (wb)
    );

    // Stage 2, outputs hold between results
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid   <= 1'b0;
            out_wb.we   <= 1'b0;
            out_taken   <= 1'b0;
            out_illegal <= 1'b0;
        end else begin
            out_valid <= s1_valid;
            if (s1_valid) begin
                out_wb      <= wb;
                out_npc     <= npc;
                out_taken   <= taken;
                out_illegal <= s1_ctrl.illegal;
            end
        end
    end

endmodule

// File: tb/mips_exec_model.svh
`ifndef MIPS_EXEC_MODEL_SVH
`define MIPS_EXEC_MODEL_SVH

typedef struct packed {
    wb_t   wb;
    word_t npc;
    logic  taken;
    logic  illegal;
} expect_t;

// Expected outcome of one instruction from the ISA rules
function automatic expect_t predict_result(input word_t instr, input word_t pc,
                                           input word_t rs_v, input word_t rt_v);
    expect_t    e;
    logic [5:0] op;
    logic [5:0] fn;
    word_t      simm;
    word_t      pc4;

    op        = instr[31:26];
    fn        = instr[5:0];
    simm      = {{16{instr[15]}}, instr[15:0]};
    pc4       = pc + 32'd4;
    e         = '0;
    e.npc     = pc4;
    e.wb.we   = 1'b1;
    e.wb.dest = instr[20:16]; // I-type writes rt
    case (op)
        6'h00: begin
            e.wb.dest = instr[15:11];
            case (fn)
                6'h20: e.wb.data = rs_v + rt_v;
                6'h22: e.wb.data = rs_v - rt_v;
                6'h24: e.wb.data = rs_v & rt_v;
                6'h25: e.wb.data = rs_v | rt_v;
                6'h00: e.wb.data = rt_v << instr[10:6];
                6'h2a: e.wb.data = {31'b0, $signed(rs_v) < $signed(rt_v)};
                6'h2b: e.wb.data = {31'b0, rs_v < rt_v};
                6'h08: begin
                    e.wb.we = 1'b0;
                    e.npc   = rs_v;
                    e.taken = 1'b1;
                end
                default: begin
                    e.wb.we   = 1'b0;
                    e.illegal = 1'b1;
                end
            endcase
        end
        6'h08: e.wb.data = rs_v + simm;
        6'h0c: e.wb.data = rs_v & {16'h0, instr[15:0]};
        6'h0d: e.wb.data = rs_v | {16'h0, instr[15:0]};
        6'h0f: e.wb.data = {instr[15:0], 16'h0};
        6'h04, 6'h05: begin
            e.wb.we = 1'b0;
            // beq wants equal, bne wants different
            if ((rs_v == rt_v) == (op == 6'h04)) begin
                e.npc   = pc4 + (simm << 2);
                e.taken = 1'b1;
            end
        end
        6'h03: begin
            e.npc     = {pc4[31:28], instr[25:0], 2'b00};
            e.taken   = 1'b1;
            e.wb.dest = 5'd31;
            e.wb.data = pc + 32'd8;
        end
        default: begin
            e.wb.we   = 1'b0;
            e.illegal = 1'b1;
        end
    endcase
    if (e.wb.dest == 5'd0) e.wb.we = 1'b0; // $zero stays zero
    return e;
endfunction

`endif

// File: tb/mips_exec_tb.sv
`timescale 1ns/10ps
module mips_exec_tb;
    import mips_exec_pkg::*;
    `include "mips_exec_model.svh"

    localparam int n_rtype   = 50;
    localparam int n_imm     = 40;
    localparam int n_set     = 20; // slt and sltu per step
    localparam int n_branch  = 15; // beq, bne, jal, jr per step
    localparam int n_stream  = 40;
    localparam int n_illegal = 40;
    localparam int total_instr = n_rtype + n_imm + 2 * n_set + 4 * n_branch
                                 + n_stream + n_illegal;

    logic    clk;
    logic    reset;
    logic    in_valid;
    word_t   in_instr;
    word_t   in_pc;
    word_t   in_rs_val;
    word_t   in_rt_val;
    logic    out_valid;
    wb_t     out_wb;
    word_t   out_npc;
    logic    out_taken;
    logic    out_illegal;

    integer  seed;
    string   cur_test;
    expect_t expq[$];
    string   nameq[$];
    expect_t head;
    string   head_name;
    logic [1:0] vhist; // Bit 1 is the strobe due now

    mips_exec_top mips_exec_top_i (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_instr    (in_instr),
        .in_pc       (in_pc),
        .in_rs_val   (in_rs_val),
        .in_rt_val   (in_rt_val),
        .out_valid   (out_valid),
        .out_wb      (out_wb),
        .out_npc     (out_npc),
        .out_taken   (out_taken),
        .out_illegal (out_illegal)
    );

    always #2 clk = ~clk;

    // Random word with the opcode and funct of one legal kind
    function automatic word_t build_instr(input int kind);
        word_t r;
        r = $random(seed);
        case (kind)
            0:  r = {6'h00, r[25:6], 6'h20}; // add
            1:  r = {6'h00, r[25:6], 6'h22};
            2:  r = {6'h00, r[25:6], 6'h24};
            3:  r = {6'h00, r[25:6], 6'h25};
            4:  r = {6'h00, r[25:6], 6'h00}; // sll
            5:  r = {6'h08, r[25:0]};
            6:  r = {6'h0c, r[25:0]};
            7:  r = {6'h0d, r[25:0]};
            8:  r = {6'h0f, r[25:0]};
            9:  r = {6'h00, r[25:6], 6'h2a}; // slt
            10: r = {6'h00, r[25:6], 6'h2b};
            11: r = {6'h04, r[25:0]};
            12: r = {6'h05, r[25:0]};
            13: r = {6'h03, r[25:0]};
            default: r = {6'h00, r[25:6], 6'h08}; // jr
        endcase
        return r;
    endfunction

    task automatic send(input word_t instr, input word_t rs_v, input word_t rt_v,
                        input int gap);
        word_t pc;
        pc = {$random(seed)} & 32'hffff_fffc;
        @(negedge clk);
        in_valid  = 1'b1;
        in_instr  = instr;
        in_pc     = pc;
        in_rs_val = rs_v;
        in_rt_val = rt_v;
        expq.push_back(predict_result(instr, pc, rs_v, rt_v));
        nameq.push_back(cur_test);
        repeat (gap) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    task automatic check_field(input string name, input string field,
                               input word_t exp_v, input word_t act_v);
        assert (exp_v === act_v) else begin
            $display("ERROR %s %s: expected %h, actual %h", name, field, exp_v, act_v);
            $display("tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // Reads values settled by the previous edge
    always @(posedge clk) begin
        if (reset) begin
            vhist = 2'b00;
        end else begin
            assert (out_valid === vhist[1]) else begin
                $display("ERROR %s out_valid: expected %b, actual %b",
                         cur_test, vhist[1], out_valid);
                $display("tests failed");
                $fatal(1, "out_valid timing");
            end
            if (vhist[1]) begin
                assert (expq.size() != 0) else begin
                    $display("A result came out with no instruction outstanding");
                    $display("tests failed");
                    $fatal(1, "empty scoreboard");
                end
                head      = expq.pop_front();
                head_name = nameq.pop_front();
                check_field(head_name, "illegal", head.illegal, out_illegal);
                check_field(head_name, "taken", head.taken, out_taken);
                check_field(head_name, "npc", head.npc, out_npc);
                check_field(head_name, "we", head.wb.we, out_wb.we);
                if (head.wb.we) begin
                    check_field(head_name, "dest", head.wb.dest, out_wb.dest);
                    check_field(head_name, "data", head.wb.data, out_wb.data);
                end
            end
            vhist = {vhist[0], in_valid};
        end
    end

    initial begin
        repeat (total_instr * 3 + 100) @(posedge clk);
        $display("Watchdog expired, the pipeline stopped producing results");
        $display("tests failed");
        $fatal(1, "timeout");
    end

    initial begin
        word_t   instr;
        word_t   a;
        word_t   b;
        expect_t probe;

        seed      = 31483;
        clk       = 1'b0;
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_instr  = '0;
        in_pc     = '0;
        in_rs_val = '0;
        in_rt_val = '0;
        cur_test  = "reset";
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        cur_test = "idle_after_reset";
        idle(8);

        cur_test = "r_type_alu";
        for (int i = 0; i < n_rtype; i++) begin
            instr = build_instr({$random(seed)} % 5);
            if (i % 5 == 0) instr[15:11] = 5'd0; // No write to rd zero
            send(instr, $random(seed), $random(seed), {$random(seed)} % 2);
        end

        cur_test = "immediate_ops";
        for (int i = 0; i < n_imm; i++) begin
            instr = build_instr(5 + {$random(seed)} % 4);
            if (i % 5 == 0) instr[20:16] = 5'd0;
            send(instr, $random(seed), $random(seed), {$random(seed)} % 2);
        end

        cur_test = "set_less_than";
        for (int i = 0; i < n_set; i++) begin
            a = $random(seed);
            b = $random(seed);
            b[31] = (i % 2 == 0) ? ~a[31] : a[31]; // Top bits differ on even steps
            send(build_instr(9), a, b, 0);
            send(build_instr(10), a, b, {$random(seed)} % 2);
        end

        cur_test = "branch_jump";
        for (int i = 0; i < n_branch; i++) begin
            a = $random(seed);
            b = (i % 2) ? a : $random(seed);
            send(build_instr(11), a, b, 0);
            send(build_instr(12), a, b, 0);
            send(build_instr(13), a, b, 0);
            send(build_instr(14), a, b, {$random(seed)} % 2);
        end

        cur_test = "stream_order";
        idle(10);
        for (int i = 0; i < n_stream; i++) begin
            // Back-to-back first, then gaps
            send(build_instr({$random(seed)} % 15), $random(seed), $random(seed),
                 (i < 20) ? 0 : {$random(seed)} % 3);
        end

        cur_test = "illegal_encoding";
        for (int i = 0; i < n_illegal; i++) begin
            do begin
                instr = $random(seed);
                if (i % 2 == 0) instr[31:26] = 6'h00; // Unknown funct
                probe = predict_result(instr, '0, '0, '0);
            end while (!probe.illegal);
            send(instr, $random(seed), $random(seed), {$random(seed)} % 2);
        end

        idle(1);
        while (expq.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);
        $display("all tests passed");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+tb
verilog/mips_exec_pkg.sv
verilog/inst_decoder.sv
verilog/alu_unit.sv
verilog/compare_unit.sv
verilog/next_pc_unit.sv
verilog/result_select.sv
verilog/mips_exec_top.sv
tb/mips_exec_tb.sv
